// File: files.f
+incdir+include
source/bus_pkg.sv
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/ramio.sv
source/word_ram.sv
source/ramio_soc.sv
testbench/tb_clock.sv
testbench/ramio_tb.sv

// File: include/ramio_cfg.svh
/*
  Build-time constants for the RAM/IO bridge: I/O register addresses,
  on-chip RAM depth and UART bit timing. Include wherever these are needed.
*/
`ifndef RAMIO_CFG_SVH
`define RAMIO_CFG_SVH

// memory-mapped I/O addresses, all at the top of the 32-bit space
// 4 LEDs in the low nibble, 0 is led on
`define RAMIO_ADDR_LED 32'hFFFF_FFFC

// byte being sent, reads all ones when the transmitter is idle
`define RAMIO_ADDR_UART_OUT 32'hFFFF_FFF8

// last byte received, reads all ones when empty and after each read
`define RAMIO_ADDR_UART_IN 32'hFFFF_FFF4

// default depth of the word RAM
// every address below the I/O window maps onto it, upper bits wrap
`define RAMIO_RAM_WORDS 256

// UART bit time in clock cycles
// kept small so a frame is only 80 cycles in simulation
// a real part would derive this from clock frequency over baud rate
`define RAMIO_CLKS_PER_BIT 8

`endif

// File: run.sh
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module ramio_tb \
  && ./obj_dir/Vramio_tb | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }

// File: source/bus_pkg.sv
/*
  Types of the client bus: addresses, data words, byte-lane enables and
  the read/write size codes shared by the bridge and the RAM.
*/
package bus_pkg;

  // byte address from the client
  typedef logic [31:0] addr_t;

  // one data word on the client and RAM side
  typedef logic [31:0] data_t;

  // per-lane write enable, bit n covers byte n of the word
  typedef logic [3:0] byte_en_t;

  // read code: bit 2 requests sign extension, low bits give the size
  // all zero means no read
  typedef logic [2:0] read_type_t;

  // write code: same size encoding as the low read bits
  // all zero means no write
  typedef logic [1:0] write_type_t;

  // size field shared by both codes
  typedef enum logic [1:0] {
    SIZE_NONE = 2'b00,
    SIZE_BYTE = 2'b01,
    SIZE_HALF = 2'b10,
    SIZE_WORD = 2'b11
  } size_e;

endpackage

// File: source/ramio.sv
/*
  Memory-mapped I/O bridge. Decodes each client access to the word RAM
  or to the LED / UART registers, turns narrow writes into byte-enabled
  word writes and extracts and extends narrow reads from the RAM word.
*/
`include "ramio_cfg.svh"

module ramio (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  bus_pkg::read_type_t   read_type_i,
  input  bus_pkg::write_type_t  write_type_i,
  input  bus_pkg::addr_t        address_i,
  input  bus_pkg::data_t        data_i,
  output bus_pkg::data_t        data_o,
  output logic                  data_out_ready_o,
  output logic                  ram_en_o,
  output bus_pkg::byte_en_t     ram_we_o,
  output logic [$clog2(`RAMIO_RAM_WORDS)-1:0] ram_addr_o,
  output bus_pkg::data_t        ram_wdata_o,
  input  bus_pkg::data_t        ram_rdata_i,
  input  logic                  ram_rvalid_i,
  output logic [3:0]            led_o,
  output logic                  uart_tx_o,
  input  logic                  uart_rx_i
);

  localparam int unsigned RAM_AW = $clog2(`RAMIO_RAM_WORDS);

  // address decode
  logic hit_led;
  logic hit_tx;
  logic hit_rx;
  logic hit_io;
  logic is_rd;
  logic is_wr;

  // RAM request tracking, set from issue until rvalid
  logic ram_pending;

  // lanes picked out of the returned RAM word
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  logic        rd_sign;

  // UART side registers and handshakes
  bus_pkg::data_t        tx_data;
  logic                  tx_go;
  logic                  tx_go_q;
  logic                  tx_busy;
  logic                  tx_queued;
  bus_pkg::data_t        rx_data;
  logic                  rx_go;
  logic                  rx_ready;
  uart_pkg::uart_byte_t  rx_byte;

  assign hit_led = (address_i == `RAMIO_ADDR_LED);
  assign hit_tx  = (address_i == `RAMIO_ADDR_UART_OUT);
  assign hit_rx  = (address_i == `RAMIO_ADDR_UART_IN);
  assign hit_io  = hit_led | hit_tx | hit_rx;
  assign is_rd   = (read_type_i != '0);
  assign is_wr   = (write_type_i != '0);

  // I/O answers in the same cycle, RAM one cycle after issue
  assign data_out_ready_o = (enable_i & hit_io) | ram_rvalid_i;

  // issue only in the first cycle of a held request
  assign ram_en_o   = enable_i & ~hit_io & (is_rd | is_wr) & ~ram_pending;
  assign ram_addr_o = address_i[RAM_AW+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_pending <= 1'b0;
    end else if (ram_en_o) begin
      ram_pending <= 1'b1;
    end else if (ram_rvalid_i) begin
      ram_pending <= 1'b0;
    end
  end

  // write lanes: data replicated, enables pick the lanes
  always_comb begin
    ram_wdata_o = data_i;
    ram_we_o    = '0;
    unique case (write_type_i)
      bus_pkg::SIZE_BYTE: begin
        ram_wdata_o = {4{data_i[7:0]}};
        ram_we_o    = 4'b0001 << address_i[1:0];
      end
      bus_pkg::SIZE_HALF: begin
        ram_wdata_o = {2{data_i[15:0]}};
        // odd half-word address writes nothing
        if (!address_i[0]) begin
          ram_we_o = address_i[1] ? 4'b1100 : 4'b0011;
        end
      end
      bus_pkg::SIZE_WORD: ram_we_o = 4'b1111;
      default: ;
    endcase
  end

  assign rd_byte = ram_rdata_i[8*address_i[1:0] +: 8];
  assign rd_half = address_i[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];
  assign rd_sign = read_type_i[2];

  // read mux; LED reads back as zero
  always_comb begin
    data_o = '0;
    if (enable_i && is_rd) begin
      if (hit_tx) begin
        data_o = tx_data;
      end else if (hit_rx) begin
        data_o = rx_data;
      end else if (!hit_led) begin
        unique case (read_type_i[1:0])
          bus_pkg::SIZE_BYTE: data_o = {{24{rd_sign & rd_byte[7]}}, rd_byte};
          bus_pkg::SIZE_HALF: begin
            // misaligned half word reads zero
            if (!address_i[0]) begin
              data_o = {{16{rd_sign & rd_half[15]}}, rd_half};
            end
          end
          bus_pkg::SIZE_WORD: data_o = ram_rdata_i;
          default: ;
        endcase
      end
    end
  end

  // LED register, active low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_o <= 4'b1111;
    end else if (enable_i && hit_led && is_wr) begin
      led_o <= data_i[3:0];
    end
  end

  // transmit handshake
  // tx_go_q covers the cycle before uart_tx raises busy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_data   <= '1;
      tx_go     <= 1'b0;
      tx_go_q   <= 1'b0;
      tx_queued <= 1'b0;
    end else begin
      tx_go_q <= 1'b0;
      if (tx_go && !tx_busy && !tx_go_q) begin
        // frame done, drop go as acknowledge
        tx_go <= 1'b0;
        if (!tx_queued && !(enable_i && hit_tx && is_wr)) begin
          tx_data <= '1;
        end
      end else if (!tx_go && tx_queued) begin
        // byte written during the last frame goes out now
        tx_go     <= 1'b1;
        tx_go_q   <= 1'b1;
        tx_queued <= 1'b0;
      end
      if (enable_i && hit_tx && is_wr) begin
        tx_data <= {24'h0, data_i[7:0]};
        if (tx_go) begin
          tx_queued <= 1'b1;
        end else begin
          tx_go   <= 1'b1;
          tx_go_q <= 1'b1;
        end
      end
    end
  end

  // receive handshake
  // a read empties the register, a ready byte is copied and acked
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_data <= '1;
      rx_go   <= 1'b1;
    end else begin
      if (enable_i && hit_rx && is_rd) begin
        rx_data <= '1;
      end else if (rx_go && rx_ready) begin
        rx_data <= {24'h0, rx_byte};
        rx_go   <= 1'b0;
      end
      // ack lasts one cycle
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
    end
  end

  uart_tx tx0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .go_i   (tx_go),
    .data_i (tx_data[7:0]),
    .busy_o (tx_busy),
    .tx_o   (uart_tx_o)
  );

  uart_rx rx0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .go_i         (rx_go),
    .rx_i         (uart_rx_i),
    .data_o       (rx_byte),
    .data_ready_o (rx_ready)
  );

endmodule

// File: source/ramio_soc.sv
/*
  Top level: the I/O bridge with its word RAM beside it. Exposes the
  client bus, the LEDs and the UART pins.
*/
`include "ramio_cfg.svh"

module ramio_soc (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  bus_pkg::read_type_t   read_type_i,
  input  bus_pkg::write_type_t  write_type_i,
  input  bus_pkg::addr_t        address_i,
  input  bus_pkg::data_t        data_i,
  output bus_pkg::data_t        data_o,
  output logic                  data_out_ready_o,
  output logic [3:0]            led_o,
  output logic                  uart_tx_o,
  input  logic                  uart_rx_i
);

  // bridge to RAM
  logic                                 ram_en;
  bus_pkg::byte_en_t                    ram_we;
  logic [$clog2(`RAMIO_RAM_WORDS)-1:0]  ram_addr;
  bus_pkg::data_t                       ram_wdata;
  bus_pkg::data_t                       ram_rdata;
  logic                                 ram_rvalid;

  ramio bridge0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .enable_i         (enable_i),
    .read_type_i      (read_type_i),
    .write_type_i     (write_type_i),
    .address_i        (address_i),
    .data_i           (data_i),
    .data_o           (data_o),
    .data_out_ready_o (data_out_ready_o),
    .ram_en_o         (ram_en),
    .ram_we_o         (ram_we),
    .ram_addr_o       (ram_addr),
    .ram_wdata_o      (ram_wdata),
    .ram_rdata_i      (ram_rdata),
    .ram_rvalid_i     (ram_rvalid),
    .led_o            (led_o),
    .uart_tx_o        (uart_tx_o),
    .uart_rx_i        (uart_rx_i)
  );

  word_ram #(
    .words (`RAMIO_RAM_WORDS)
  ) ram0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .en_i     (ram_en),
    .we_i     (ram_we),
    .addr_i   (ram_addr),
    .wdata_i  (ram_wdata),
    .rdata_o  (ram_rdata),
    .rvalid_o (ram_rvalid)
  );

endmodule

// File: source/uart_pkg.sv
/*
  UART types: the serial data byte and the state encodings of the
  8N1 transmitter and receiver.
*/
package uart_pkg;

  // one serial data byte
  typedef logic [7:0] uart_byte_t;

  // transmitter walks start bit, 8 data bits, stop bit
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  // receiver adds a done state that holds the byte until acknowledged
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_DONE
  } rx_state_e;

endpackage

// File: source/uart_rx.sv
/*
  8N1 serial receiver. While go_i is high it waits for a start edge,
  samples each bit in its middle and then holds data_ready_o with the
  byte on data_o until go_i is lowered as the acknowledge.
*/
`include "ramio_cfg.svh"

module uart_rx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  go_i,
  input  logic                  rx_i,
  output uart_pkg::uart_byte_t  data_o,
  output logic                  data_ready_o
);

  localparam int unsigned CPB = `RAMIO_CLKS_PER_BIT;
  localparam int unsigned CW  = $clog2(CPB + 1);

  uart_pkg::rx_state_e  state;
  logic [CW-1:0]        clk_cnt;
  logic [2:0]           bit_cnt;
  // two-flop synchronizer, then one more for the edge
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 bit_end;
  logic                 half_end;

  assign bit_end  = (clk_cnt == CW'(CPB - 1));
  assign half_end = (clk_cnt == CW'(CPB / 2 - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= uart_pkg::RX_IDLE;
      clk_cnt      <= '0;
      bit_cnt      <= '0;
      data_ready_o <= 1'b0;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      unique case (state)
        uart_pkg::RX_IDLE: begin
          clk_cnt <= '0;
          // falling edge opens the start bit
          if (go_i && rx_prev && !rx_sync) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          // middle of start bit, drop glitches
          if (half_end) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end
          end
        end
        uart_pkg::RX_STOP: begin
          // bad stop bit discards the byte
          if (bit_end) begin
            data_ready_o <= rx_sync;
            state        <= rx_sync ? uart_pkg::RX_DONE : uart_pkg::RX_IDLE;
          end
        end
        uart_pkg::RX_DONE: begin
          if (!go_i) begin
            data_ready_o <= 1'b0;
            state        <= uart_pkg::RX_IDLE;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // shift in LSB first at each bit middle
  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && bit_end) begin
      data_o <= {rx_sync, data_o[7:1]};
    end
  end

endmodule

// File: source/uart_tx.sv
/*
  8N1 serial transmitter. Raising go_i starts a frame with the byte on
  data_i; busy_o is high for the frame, and go_i must drop once busy_o
  falls before the next frame can start.
*/
`include "ramio_cfg.svh"

module uart_tx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  go_i,
  input  uart_pkg::uart_byte_t  data_i,
  output logic                  busy_o,
  output logic                  tx_o
);

  localparam int unsigned CPB = `RAMIO_CLKS_PER_BIT;
  localparam int unsigned CW  = $clog2(CPB + 1);

  uart_pkg::tx_state_e   state;
  uart_pkg::uart_byte_t  shift_q;
  logic [CW-1:0]         clk_cnt;
  logic [2:0]            bit_cnt;
  // frame sent, waiting for go to drop
  logic                  done_q;
  logic                  bit_end;
  logic                  start;

  assign bit_end = (clk_cnt == CW'(CPB - 1));
  assign start   = (state == uart_pkg::TX_IDLE) & go_i & ~done_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= uart_pkg::TX_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      done_q  <= 1'b0;
      busy_o  <= 1'b0;
      tx_o    <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      unique case (state)
        uart_pkg::TX_IDLE: begin
          clk_cnt <= '0;
          if (!go_i) begin
            done_q <= 1'b0;
          end
          if (start) begin
            // start bit goes out now
            tx_o   <= 1'b0;
            busy_o <= 1'b1;
            state  <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            tx_o    <= shift_q[0];
            bit_cnt <= '0;
            state   <= uart_pkg::TX_DATA;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              tx_o  <= 1'b1;
              state <= uart_pkg::TX_STOP;
            end else begin
              tx_o    <= shift_q[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_end) begin
            busy_o <= 1'b0;
            done_q <= 1'b1;
            state  <= uart_pkg::TX_IDLE;
          end
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // byte latched at start, LSB first
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= data_i;
    end else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

// File: source/word_ram.sv
/*
  Single-port word RAM with per-byte write enables. Every enabled cycle
  is accepted; read data and a valid strobe follow one cycle later,
  for writes as well as reads.
*/
`include "ramio_cfg.svh"

module word_ram #(
  parameter int unsigned words = `RAMIO_RAM_WORDS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en_i,
  input  bus_pkg::byte_en_t         we_i,
  input  logic [$clog2(words)-1:0]  addr_i,
  input  bus_pkg::data_t            wdata_i,
  output bus_pkg::data_t            rdata_o,
  output logic                      rvalid_o
);

  // storage
  bus_pkg::data_t mem [words];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (we_i[lane]) begin
          mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
        end
      end
    end
  end

  // read port returns the word as it was before this cycle's write
  always_ff @(posedge clk) begin
    if (en_i) begin
      rdata_o <= mem[addr_i];
    end
  end

  // valid strobe one cycle after each request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= en_i;
    end
  end

endmodule

// File: testbench/ramio_tb.sv
/*
  Testbench for the RAM/IO bridge top level. Random word and narrow
  accesses are checked against a RAM model, then the LED and UART
  registers, with frames decoded on the line and looped back.
*/
`include "ramio_cfg.svh"

module ramio_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned AW = $clog2(`RAMIO_RAM_WORDS);
  localparam int unsigned CPB = `RAMIO_CLKS_PER_BIT;
  localparam int unsigned READY_TIMEOUT = 8;
  localparam int unsigned POLL_LIMIT = 20;
  localparam bus_pkg::read_type_t RD_WORD = 3'b011;
  localparam bus_pkg::write_type_t WR_BYTE = 2'b01;
  localparam bus_pkg::write_type_t WR_HALF = 2'b10;
  localparam bus_pkg::write_type_t WR_WORD = 2'b11;

  logic                  clk;
  logic                  rst_n;
  logic                  enable;
  bus_pkg::read_type_t   read_type;
  bus_pkg::write_type_t  write_type;
  bus_pkg::addr_t        address;
  bus_pkg::data_t        wdata;
  bus_pkg::data_t        rdata;
  logic                  ready;
  logic [3:0]            led;
  logic                  uart_tx;
  logic                  uart_rx;
  // serial line mux selects loopback or the tb-driven line
  logic                  loopback;
  logic                  line_tb;
  // ram_en seen in the first cycle of the last access
  logic                  last_issued;

  // expected contents of the word RAM
  bus_pkg::data_t model [`RAMIO_RAM_WORDS];

  assign uart_rx = loopback ? uart_tx : line_tb;

  tb_clock clk0 (.clk_o(clk));

  ramio_soc dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .enable_i         (enable),
    .read_type_i      (read_type),
    .write_type_i     (write_type),
    .address_i        (address),
    .data_i           (wdata),
    .data_o           (rdata),
    .data_out_ready_o (ready),
    .led_o            (led),
    .uart_tx_o        (uart_tx),
    .uart_rx_i        (uart_rx)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_fail(input string msg);
    stop_run($sformatf("Fail at %0t ns: %s", $time, msg));
  endtask

  task automatic check_data(input bus_pkg::data_t got, input bus_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s returned %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("led_o is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_byte(input uart_pkg::uart_byte_t got, input uart_pkg::uart_byte_t exp);
    if (got !== exp) begin
      report_fail($sformatf("serial byte %h, expected %h", got, exp));
    end
  endtask

  function automatic logic is_io(input bus_pkg::addr_t a);
    return a == `RAMIO_ADDR_LED || a == `RAMIO_ADDR_UART_OUT || a == `RAMIO_ADDR_UART_IN;
  endfunction

  // lane merge with bytes at any offset and half words only on even offsets
  function automatic bus_pkg::data_t merge_write(input bus_pkg::data_t old,
      input bus_pkg::write_type_t wt, input logic [1:0] off, input bus_pkg::data_t d);
    bus_pkg::data_t w;
    w = old;
    case (wt)
      WR_BYTE: w[8*off +: 8] = d[7:0];
      WR_HALF: begin
        if (off == 2'd0) begin
          w[15:0] = d[15:0];
        end else if (off == 2'd2) begin
          w[31:16] = d[15:0];
        end
      end
      WR_WORD: w = d;
      default: ;
    endcase
    return w;
  endfunction

  // narrow read with sign or zero extension
  // odd half word gives zero
  function automatic bus_pkg::data_t extract_read(input bus_pkg::data_t word,
      input bus_pkg::read_type_t rt, input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (rt[1:0])
      2'b01: return rt[2] ? {{24{b[7]}}, b} : {24'h0, b};
      2'b10: begin
        if (off[0]) begin
          return '0;
        end
        return rt[2] ? {{16{h[15]}}, h} : {16'h0, h};
      end
      2'b11: return word;
      default: return '0;
    endcase
  endfunction

  // one client access presented on a falling edge and held until ready
  task automatic bus_access(input bus_pkg::read_type_t rt, input bus_pkg::write_type_t wt,
      input bus_pkg::addr_t a, input bus_pkg::data_t d, output bus_pkg::data_t q);
    int unsigned lat;
    int unsigned want;
    want = is_io(a) ? 0 : 1;
    @(negedge clk);
    enable = 1'b1;
    read_type = rt;
    write_type = wt;
    address = a;
    wdata = d;
    #1;
    last_issued = dut0.ram_en;
    for (lat = 0; lat < READY_TIMEOUT; lat++) begin
      if (ready === 1'b1) begin
        break;
      end
      @(negedge clk);
      #1;
    end
    if (lat == READY_TIMEOUT) begin
      stop_run($sformatf("Timeout: data_out_ready_o never rose for the access at %h", a));
    end
    q = rdata;
    if (lat != want) begin
      report_fail($sformatf("ready after %0d cycles at %h, expected %0d", lat, a, want));
    end
    @(negedge clk);
    enable = 1'b0;
    read_type = '0;
    write_type = '0;
  endtask

  task automatic write_bus(input bus_pkg::write_type_t wt, input bus_pkg::addr_t a,
                           input bus_pkg::data_t d);
    bus_pkg::data_t q;
    bus_access(3'b000, wt, a, d, q);
    if (!is_io(a)) begin
      model[a[AW+1:2]] = merge_write(model[a[AW+1:2]], wt, a[1:0], d);
    end
  endtask

  task automatic read_check(input bus_pkg::read_type_t rt, input bus_pkg::addr_t a);
    bus_pkg::data_t q;
    bus_access(rt, 2'b00, a, '0, q);
    check_data(q, extract_read(model[a[AW+1:2]], rt, a[1:0]),
               $sformatf("read type %b at %h", rt, a));
  endtask

  function automatic bus_pkg::addr_t random_word_addr();
    return bus_pkg::addr_t'($urandom_range(0, `RAMIO_RAM_WORDS - 1)) << 2;
  endfunction

  // sample uart_tx_o in the middle of each bit of one frame
  task automatic decode_frame(input uart_pkg::uart_byte_t exp);
    uart_pkg::uart_byte_t got;
    int unsigned n;
    int unsigned k;
    got = '0;
    for (n = 0; n < 4; n++) begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        break;
      end
    end
    if (n == 4) begin
      stop_run("Timeout: no start bit on uart_tx_o after the UART out write");
    end
    repeat (CPB / 2) @(negedge clk);
    if (uart_tx !== 1'b0) begin
      report_fail("start bit is not low at its middle");
    end
    // LSB first
    for (k = 0; k < 8; k++) begin
      repeat (CPB) @(negedge clk);
      got[k] = uart_tx;
    end
    repeat (CPB) @(negedge clk);
    if (uart_tx !== 1'b1) begin
      report_fail("stop bit is not high at its middle");
    end
    check_byte(got, exp);
  endtask

  // tb-side 8N1 frame with CPB cycles per bit
  task automatic send_serial(input uart_pkg::uart_byte_t b);
    logic [9:0] frame;
    int unsigned k;
    frame = {1'b1, b, 1'b0};
    for (k = 0; k < 10; k++) begin
      @(negedge clk);
      line_tb = frame[k];
      repeat (CPB - 1) @(negedge clk);
    end
  endtask

  // poll UART in until a byte shows up and check that the read empties it
  task automatic receive_check(input uart_pkg::uart_byte_t exp);
    bus_pkg::data_t q;
    int unsigned n;
    for (n = 0; n < POLL_LIMIT; n++) begin
      bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_UART_IN, '0, q);
      if (q !== '1) begin
        break;
      end
    end
    if (n == POLL_LIMIT) begin
      stop_run("Timeout: no byte arrived in the UART in register");
    end
    check_data(q, {24'h0, exp}, "UART in");
    bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_UART_IN, '0, q);
    check_data(q, '1, "UART in after read");
  endtask

  initial begin
    bus_pkg::data_t        q;
    bus_pkg::addr_t        a;
    bus_pkg::read_type_t   rt;
    uart_pkg::uart_byte_t  tx_byte;
    logic [3:0]            led_val;
    int unsigned           i;
    int unsigned           op;
    enable = 1'b0;
    read_type = '0;
    write_type = '0;
    address = '0;
    wdata = '0;
    rst_n = 1'b0;
    loopback = 1'b1;
    line_tb = 1'b1;
    last_issued = 1'b0;
    void'($urandom(39));
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // reset values
    check_led(led, 4'b1111);
    if (uart_tx !== 1'b1) begin
      report_fail("uart_tx_o is not idle high after reset");
    end
    bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_UART_OUT, '0, q);
    check_data(q, '1, "UART out after reset");
    bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_UART_IN, '0, q);
    check_data(q, '1, "UART in after reset");

    // fill every word so later reads are defined
    for (i = 0; i < `RAMIO_RAM_WORDS; i++) begin
      write_bus(WR_WORD, bus_pkg::addr_t'(i) << 2, $urandom);
    end
    // random mix of word writes and reads
    for (i = 0; i < 400; i++) begin
      if ($urandom_range(0, 1) == 1) begin
        write_bus(WR_WORD, random_word_addr(), $urandom);
      end else begin
        read_check(RD_WORD, random_word_addr());
      end
    end

    // narrow writes and signed or unsigned reads at any offset
    for (i = 0; i < 300; i++) begin
      op = $urandom_range(0, 2);
      a = random_word_addr() | bus_pkg::addr_t'($urandom_range(0, 3));
      if (op == 0) begin
        write_bus(WR_BYTE, a, $urandom);
      end else if (op == 1) begin
        write_bus(WR_HALF, a, $urandom);
      end else begin
        rt = {1'($urandom_range(0, 1)), 2'($urandom_range(1, 3))};
        read_check(rt, a);
      end
    end

    // LED register with no RAM request on either access
    // value differs from the reset pattern so the write is visible
    led_val = 4'($urandom_range(0, 14));
    write_bus(WR_WORD, `RAMIO_ADDR_LED, {28'h0, led_val});
    if (last_issued !== 1'b0) begin
      report_fail("LED write issued a RAM request");
    end
    check_led(led, led_val);
    bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_LED, '0, q);
    check_data(q, '0, "LED read");
    if (last_issued !== 1'b0) begin
      report_fail("LED read issued a RAM request");
    end

    // decode the transmitted frame while reading UART out back
    tx_byte = 8'($urandom);
    write_bus(WR_BYTE, `RAMIO_ADDR_UART_OUT, {24'h0, tx_byte});
    fork
      decode_frame(tx_byte);
      begin
        bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_UART_OUT, '0, q);
        check_data(q, {24'h0, tx_byte}, "UART out while sending");
      end
    join
    for (i = 0; i < POLL_LIMIT; i++) begin
      bus_access(RD_WORD, 2'b00, `RAMIO_ADDR_UART_OUT, '0, q);
      if (q === '1) begin
        break;
      end
      check_data(q, {24'h0, tx_byte}, "UART out at frame end");
    end
    if (i == POLL_LIMIT) begin
      stop_run("Timeout: UART out register did not return to idle after the frame");
    end

    // receive the looped-back byte and then one driven by the tb
    receive_check(tx_byte);
    @(negedge clk);
    loopback = 1'b0;
    tx_byte = 8'($urandom);
    send_serial(tx_byte);
    receive_check(tx_byte);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: testbench/tb_clock.sv
/*
  Free-running testbench clock, 8 ns period, starting low.
*/
module tb_clock (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    // half period of 4 ns
    forever #4 clk_o = ~clk_o;
  end

endmodule
